// File: filelist.f
src/ccrPkg.sv
src/aluOpsPkg.sv
src/aluDecoder.sv
src/aluShifter.sv
src/aluBcdCorrect.sv
src/aluCore.sv
src/ccrUpdate.sv
src/aluUnit.sv
test/aluUnit_props.sv
test/aluUnitTb.sv

// File: run.sh
#!/bin/sh
# Build the ALU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f filelist.f --top-module aluUnitTb \
	--Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ValuUnitTb > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/aluBcdCorrect.sv
/* Decimal adjust of a binary byte sum or difference for ABCD and SBCD */
`timescale 1ns/1ns
`default_nettype none

module aluBcdCorrect (
	input wire aluOpsPkg::aluByte binary,
	input wire logic halfCarry,
	input wire logic carry,
	input wire logic isAdd,
	output aluOpsPkg::aluByte decimal,
	output logic decimalCarry
);

	logic lowAdjust;
	logic highAdjust;
	logic [7:0] correction;

	always_comb begin
		// Low digit out of range or carried past a decimal 9
		lowAdjust = halfCarry || (binary[3:0] > 4'd9);
		// Whole byte beyond 99 or a binary carry or borrow out
		highAdjust = carry || (binary > 8'h99);

		correction = {highAdjust ? 4'h6 : 4'h0, lowAdjust ? 4'h6 : 4'h0};

		if (isAdd) begin
			decimal = binary + correction;
		end else begin
			decimal = binary - correction;
		end

		// Tens digit wrapped, carry for add or borrow for subtract
		decimalCarry = highAdjust;
	end

endmodule

`default_nettype wire

// File: src/aluCore.sv
/* ALU datapath with adder, logic, extend, shifter and BCD correction,
   result select and raw condition flags */
`timescale 1ns/1ns
`default_nettype none

module aluCore (
	input wire aluOpsPkg::aluCtrl ctrl,
	input wire ccrPkg::ccrFlags ccr,
	output aluOpsPkg::aluWord coreResult,
	output ccrPkg::ccrFlags rawFlags
);
	import aluOpsPkg::*;

	aluOp op;
	aluWord src;
	aluWord dst;
	logic sizeByte;
	logic isBcd;
	logic isSub;
	logic addCin;
	aluWord lhs;
	aluWord rhs;
	logic [16:0] wordSum;
	logic [8:0] byteSum;
	logic addCarry;
	logic addOverflow;
	logic halfCarry;
	logic lhsSign;
	logic rhsSign;
	logic sumSign;
	logic dstSign;
	logic fillBit;
	aluWord shifted;
	logic outBit;
	logic msbChanged;
	aluByte bcdValue;
	logic bcdCarry;
	aluWord opResult;

	assign op = ctrl.req.op;
	assign src = ctrl.req.src;
	assign dst = ctrl.req.dst;

	// EXT always works on the word, decimal ops only on a byte
	assign isBcd = (op == opAbcd) || (op == opSbcd);
	assign sizeByte = (ctrl.req.isByte && (op != opExt)) || isBcd;

	// Adder set up, lhs op rhs
	always_comb begin
		isSub = (op == opSub) || (op == opSubx) || (op == opNeg) || (op == opSbcd);
		// Extended ops chain through X
		addCin = (op == opAddx || op == opSubx || isBcd) ? ccr.x : 1'b0;
		// NEG is 0 - dst
		lhs = (op == opNeg) ? '0 : dst;
		rhs = (op == opNeg) ? dst : src;

		if (isSub) begin
			wordSum = {1'b0, lhs} - {1'b0, rhs} - {16'd0, addCin};
			byteSum = {1'b0, lhs[7:0]} - {1'b0, rhs[7:0]} - {8'd0, addCin};
		end else begin
			wordSum = {1'b0, lhs} + {1'b0, rhs} + {16'd0, addCin};
			byteSum = {1'b0, lhs[7:0]} + {1'b0, rhs[7:0]} + {8'd0, addCin};
		end

		// Carry or borrow out of the sized operand
		addCarry = sizeByte ? byteSum[8] : wordSum[16];
		lhsSign = sizeByte ? lhs[7] : lhs[15];
		rhsSign = sizeByte ? rhs[7] : rhs[15];
		sumSign = sizeByte ? byteSum[7] : wordSum[15];
		if (isSub) begin
			addOverflow = (lhsSign != rhsSign) && (sumSign != lhsSign);
		end else begin
			addOverflow = (lhsSign == rhsSign) && (sumSign != lhsSign);
		end

		// Carry into bit 4, used by the decimal adjust
		halfCarry = lhs[4] ^ rhs[4] ^ byteSum[4];
	end

	// Shifter fill bit
	assign dstSign = sizeByte ? dst[7] : dst[15];
	always_comb begin
		case (op)
			opAsr, opRol: fillBit = dstSign;
			opRor: fillBit = dst[0];
			opRoxl, opRoxr: fillBit = ccr.x;
			default: fillBit = 1'b0;
		endcase
	end

	aluShifter shifter_i (
		.data(dst),
		.isByte(sizeByte),
		.shiftRight(ctrl.shiftRight),
		.fillBit(fillBit),
		.shifted(shifted),
		.outBit(outBit),
		.msbChanged(msbChanged)
	);

	aluBcdCorrect bcdCorrect_i (
		.binary(byteSum[7:0]),
		.halfCarry(halfCarry),
		.carry(byteSum[8]),
		.isAdd(op == opAbcd),
		.decimal(bcdValue),
		.decimalCarry(bcdCarry)
	);

	// Operation select
	always_comb begin
		case (op)
			opAnd: opResult = src & dst;
			opOr: opResult = src | dst;
			opEor: opResult = src ^ dst;
			opExt: opResult = {{8{dst[7]}}, dst[7:0]};
			opAdd, opAddx, opSub, opSubx, opNeg: opResult = wordSum[15:0];
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: opResult = shifted;
			opAbcd, opSbcd: opResult = {8'h00, bcdValue};
			default: opResult = '0;
		endcase
	end

	// Byte ops keep the destination's upper byte
	assign coreResult = sizeByte ? {dst[15:8], opResult[7:0]} : opResult;

	always_comb begin
		rawFlags.n = sizeByte ? coreResult[7] : coreResult[15];
		rawFlags.z = sizeByte ? (coreResult[7:0] == 8'h00) : (coreResult == '0);

		// Logic and EXT clear V and C
		rawFlags.x = ccr.x;
		rawFlags.v = 1'b0;
		rawFlags.c = 1'b0;

		case (op)
			opAdd, opAddx, opSub, opSubx, opNeg: begin
				rawFlags.x = addCarry;
				rawFlags.c = addCarry;
				rawFlags.v = addOverflow;
			end
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: begin
				// X is masked off for ROL and ROR
				rawFlags.x = outBit;
				rawFlags.c = outBit;
				rawFlags.v = (op == opAsl) ? msbChanged : 1'b0;
			end
			opAbcd, opSbcd: begin
				rawFlags.x = bcdCarry;
				rawFlags.c = bcdCarry;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/aluDecoder.sv
/* Input stage of the ALU, registers a request with its shift direction,
   flag mask and sticky Z control */
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid,
	input wire aluOpsPkg::aluRequest request,
	output logic ctrlValid,
	output aluOpsPkg::aluCtrl ctrl
);
	import aluOpsPkg::*;
	import ccrPkg::*;

	aluCtrl nextCtrl;

	always_comb begin
		nextCtrl.req = request;

		// Direction only matters to the shifter
		case (request.op)
			opAsr, opLsr, opRor, opRoxr: nextCtrl.shiftRight = 1'b1;
			default: nextCtrl.shiftRight = 1'b0;
		endcase

		// Which flags each operation may touch
		case (request.op)
			opAnd, opOr, opEor, opExt, opRol, opRor: begin
				nextCtrl.flagMask = maskNzvc;
				nextCtrl.zSticky = 1'b0;
			end
			// Multi-precision ops only ever clear Z
			opAddx, opSubx: begin
				nextCtrl.flagMask = maskAll;
				nextCtrl.zSticky = 1'b1;
			end
			opAbcd, opSbcd: begin
				nextCtrl.flagMask = maskXzc;
				nextCtrl.zSticky = 1'b1;
			end
			// Plain arithmetic, arithmetic and logical shifts, rotate through X
			default: begin
				nextCtrl.flagMask = maskAll;
				nextCtrl.zSticky = 1'b0;
			end
		endcase
	end

	// Pipeline valid bit
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlValid <= 1'b0;
		end else begin
			ctrlValid <= valid;
		end
	end

	// Payload only moves with a new request
	always_ff @(posedge clk) begin
		if (valid) begin
			ctrl <= nextCtrl;
		end
	end

endmodule

`default_nettype wire

// File: src/aluOpsPkg.sv
/* Data word types, decoded operation codes and the ALU request and control structs */
`default_nettype none

package aluOpsPkg;

	// Fixed by the architecture
	localparam int wordWidth = 16;
	localparam int byteWidth = 8;
	localparam int opWidth = 5;

	typedef logic [wordWidth-1:0] aluWord;
	typedef logic [byteWidth-1:0] aluByte;

	// Operation codes, already decoded from the instruction
	typedef enum logic [opWidth-1:0] {
		opAnd, opOr, opEor,
		opAdd, opAddx, opSub, opSubx, opNeg,
		opExt,
		opAsl, opAsr, opLsl, opLsr,
		opRol, opRor, opRoxl, opRoxr,
		opAbcd, opSbcd
	} aluOp;

	// What the outside hands in with valid
	typedef struct packed {
		aluOp op;
		logic isByte;
		aluWord src;
		aluWord dst;
	} aluRequest;

	// Request plus the fields derived from its operation
	typedef struct packed {
		aluRequest req;
		logic shiftRight;
		ccrPkg::flagMask flagMask;
		logic zSticky;
	} aluCtrl;

endpackage

`default_nettype wire

// File: src/aluShifter.sv
/* Single position shift and rotate of a byte or word, with the bit shifted out */
`timescale 1ns/1ns
`default_nettype none

module aluShifter (
	input wire aluOpsPkg::aluWord data,
	input wire logic isByte,
	input wire logic shiftRight,
	input wire logic fillBit,
	output aluOpsPkg::aluWord shifted,
	output logic outBit,
	output logic msbChanged
);

	always_comb begin
		if (isByte) begin
			// Upper byte passes through untouched
			if (shiftRight) begin
				shifted = {data[15:8], fillBit, data[7:1]};
				outBit = data[0];
				msbChanged = 1'b0;
			end else begin
				shifted = {data[15:8], data[6:0], fillBit};
				outBit = data[7];
				// Sign flips when bit 6 moves into bit 7 with another value
				msbChanged = data[7] ^ data[6];
			end
		end else begin
			if (shiftRight) begin
				shifted = {fillBit, data[15:1]};
				outBit = data[0];
				msbChanged = 1'b0;
			end else begin
				shifted = {data[14:0], fillBit};
				outBit = data[15];
				msbChanged = data[15] ^ data[14];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/aluUnit.sv
/* Top of the 16 bit execution unit, decoder, datapath and CCR stage */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid,
	input wire aluOpsPkg::aluRequest request,
	input wire logic ccrLoad,
	input wire ccrPkg::ccrFlags ccrIn,
	output logic done,
	output aluOpsPkg::aluWord result,
	output ccrPkg::ccrFlags ccr
);
	import aluOpsPkg::*;
	import ccrPkg::*;

	logic ctrlValid;
	aluCtrl ctrl;
	aluWord coreResult;
	ccrFlags rawFlags;

	// First cycle, capture and decode
	aluDecoder decoder_i (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.request(request),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	// Second cycle, compute against the live CCR
	aluCore core_i (
		.ctrl(ctrl),
		.ccr(ccr),
		.coreResult(coreResult),
		.rawFlags(rawFlags)
	);

	ccrUpdate ccrUpdate_i (
		.clk(clk),
		.reset(reset),
		.ctrlValid(ctrlValid),
		.flagMask(ctrl.flagMask),
		.zSticky(ctrl.zSticky),
		.rawFlags(rawFlags),
		.coreResult(coreResult),
		.ccrLoad(ccrLoad),
		.ccrIn(ccrIn),
		.done(done),
		.result(result),
		.ccr(ccr)
	);

endmodule

`default_nettype wire

// File: src/ccrPkg.sv
/* Condition code flags of the 68000 CCR and the per-operation flag masks */
`default_nettype none

package ccrPkg;

	// Low five bits of the 68000 status register
	typedef struct packed {
		logic x;
		logic n;
		logic z;
		logic v;
		logic c;
	} ccrFlags;

	// Same layout as the flags, a set bit lets that flag change
	typedef ccrFlags flagMask;

	// Every flag
	localparam flagMask maskAll = flagMask'(5'b11111);
	// Logic, EXT and plain rotates leave X alone
	localparam flagMask maskNzvc = flagMask'(5'b01111);
	// Decimal ops keep N and V
	localparam flagMask maskXzc = flagMask'(5'b10101);

endpackage

`default_nettype wire

// File: src/ccrUpdate.sv
/* Output stage of the ALU, masked CCR merge with sticky Z and direct load,
   plus the result and done registers */
`timescale 1ns/1ns
`default_nettype none

module ccrUpdate (
	input wire logic clk,
	input wire logic reset,
	input wire logic ctrlValid,
	input wire ccrPkg::flagMask flagMask,
	input wire logic zSticky,
	input wire ccrPkg::ccrFlags rawFlags,
	input wire aluOpsPkg::aluWord coreResult,
	input wire logic ccrLoad,
	input wire ccrPkg::ccrFlags ccrIn,
	output logic done,
	output aluOpsPkg::aluWord result,
	output ccrPkg::ccrFlags ccr
);
	import ccrPkg::*;

	ccrFlags merged;

	always_comb begin
		// Masked flags keep their old value
		merged = ccrFlags'((rawFlags & flagMask) | (ccr & ~flagMask));
		// Z can be cleared but never set
		if (zSticky) begin
			merged.z = rawFlags.z & ccr.z;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			result <= '0;
			ccr <= '0;
		end else begin
			done <= ctrlValid;
			if (ctrlValid) begin
				result <= coreResult;
			end
			// Direct load wins over a completing operation
			if (ccrLoad) begin
				ccr <= ccrIn;
			end else if (ctrlValid) begin
				ccr <= merged;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/aluUnitTb.sv
/* Testbench of the ALU top level with xorshift stimulus, a reference model of
   the result and flag rules, and lockstep checks at every falling edge */
`timescale 1ns/1ns
`default_nettype none

module aluUnitTb;
	import aluOpsPkg::*;
	import ccrPkg::*;

	localparam int numOps = 3000;
	// Run length plus reset and drain margin
	localparam int cycleLimit = numOps + 20;

	logic clk;
	logic reset;
	logic valid;
	aluRequest request;
	logic ccrLoad;
	ccrFlags ccrIn;
	logic done;
	aluWord result;
	ccrFlags ccr;

	logic [31:0] rngState;
	int cycleCount = 0;
	int errorCount = 0;
	// Model state, CCR after the last edge and the op in its second cycle
	ccrFlags refCcr;
	logic stageValid;
	aluRequest stageReq;
	aluWord expected[$];

	aluUnit aluUnit_i (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.request(request),
		.ccrLoad(ccrLoad),
		.ccrIn(ccrIn),
		.done(done),
		.result(result),
		.ccr(ccr)
	);

	bind aluUnit aluUnitProps props_i (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.done(done),
		.ccrLoad(ccrLoad),
		.ccrIn(ccrIn),
		.ccr(ccr),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stopOnFailure();
		$display("Regression failed");
		$fatal(1, "stopping at the first failure");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout, test still running after %0d cycles", cycleCount);
			stopOnFailure();
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] v);
		logic [31:0] t;
		t = v ^ (v << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	// Two's complement value of a w bit field
	function automatic int signedOf(input int v, input int w);
		return (v >= (1 << (w - 1))) ? v - (1 << w) : v;
	endfunction

	function automatic int bcdToInt(input int b);
		return ((b >> 4) & 15) * 10 + (b & 15);
	endfunction

	function automatic int intToBcd(input int v);
		return ((v / 10) << 4) | (v % 10);
	endfunction

	// Two random decimal digits
	function automatic aluByte bcdByte(input logic [7:0] r);
		return {r[7:4] % 4'd10, r[3:0] % 4'd10};
	endfunction

	task automatic predict(input aluRequest r, input ccrFlags old, output aluWord res,
			output ccrFlags nf);
		int w;
		int msk;
		int d;
		int s;
		int cin;
		int t;
		int st;
		int fill;
		int value;
		logic outBit;
		logic isBcd;
		logic zero;
		isBcd = (r.op == opAbcd) || (r.op == opSbcd);
		// EXT is a word op, decimal ops are byte only
		w = ((r.isByte || isBcd) && (r.op != opExt)) ? 8 : 16;
		msk = (1 << w) - 1;
		d = int'(r.dst) & msk;
		s = int'(r.src) & msk;
		cin = (r.op == opAddx || r.op == opSubx || isBcd) ? int'(old.x) : 0;
		nf = old;
		if (!isBcd) nf.v = 1'b0;
		nf.c = 1'b0;
		value = 0;
		case (r.op)
			opAnd: value = d & s;
			opOr: value = d | s;
			opEor: value = d ^ s;
			opExt: value = signedOf(d & 255, 8) & msk;
			opAdd, opAddx, opSub, opSubx, opNeg: begin
				if (r.op == opNeg) begin
					t = -d;
					st = -signedOf(d, w);
				end else if (r.op == opSub || r.op == opSubx) begin
					t = d - s - cin;
					st = signedOf(d, w) - signedOf(s, w) - cin;
				end else begin
					t = d + s + cin;
					st = signedOf(d, w) + signedOf(s, w) + cin;
				end
				value = t & msk;
				// Carry past the top or borrow below zero
				nf.c = (t < 0) || (t > msk);
				nf.x = nf.c;
				nf.v = (st < -(1 << (w - 1))) || (st >= (1 << (w - 1)));
			end
			opAsl, opLsl, opRol, opRoxl: begin
				outBit = ((d >> (w - 1)) & 1) != 0;
				fill = (r.op == opRol) ? int'(outBit) : (r.op == opRoxl) ? int'(old.x) : 0;
				value = ((d << 1) | fill) & msk;
				nf.c = outBit;
				if (r.op != opRol) nf.x = outBit;
				// Sign change on an arithmetic left shift
				nf.v = (r.op == opAsl) && ((((value ^ d) >> (w - 1)) & 1) != 0);
			end
			opAsr, opLsr, opRor, opRoxr: begin
				outBit = (d & 1) != 0;
				case (r.op)
					opAsr: fill = (d >> (w - 1)) & 1;
					opRor: fill = int'(outBit);
					opRoxr: fill = int'(old.x);
					default: fill = 0;
				endcase
				value = (d >> 1) | (fill << (w - 1));
				nf.c = outBit;
				if (r.op != opRor) nf.x = outBit;
			end
			opAbcd, opSbcd: begin
				if (r.op == opAbcd) begin
					t = bcdToInt(d) + bcdToInt(s) + cin;
					nf.c = t > 99;
				end else begin
					t = bcdToInt(d) - bcdToInt(s) - cin;
					nf.c = t < 0;
				end
				value = intToBcd((t + 100) % 100);
				nf.x = nf.c;
			end
			default: value = 0;
		endcase
		zero = (value & msk) == 0;
		// N and V stay as they were for decimal ops
		if (!isBcd) nf.n = ((value >> (w - 1)) & 1) != 0;
		// Multi-precision ops may only clear Z
		if (r.op == opAddx || r.op == opSubx || isBcd) begin
			nf.z = old.z && zero;
		end else begin
			nf.z = zero;
		end
		res = (w == 8) ? {r.dst[15:8], 8'(value)} : 16'(value);
	endtask

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] want);
		assert (got === want) else begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
			errorCount++;
			stopOnFailure();
		end
	endtask

	task automatic checkOutputs();
		checkValue("done", {15'd0, done}, {15'd0, expected.size() != 0});
		if (expected.size() != 0) begin
			checkValue("result", result, expected.pop_front());
		end
		checkValue("ccr", {11'd0, ccr}, {11'd0, refCcr});
	endtask

	// New inputs for the next rising edge
	task automatic driveRandom(input logic active);
		logic [31:0] r;
		rngState = xorshift(rngState);
		r = rngState;
		valid = active && (r[1:0] != 2'b00);
		request.op = aluOp'(r[20:16] % 5'd19);
		request.isByte = r[2];
		ccrLoad = active && (r[5:3] == 3'b000);
		ccrIn = ccrFlags'(r[10:6]);
		rngState = xorshift(rngState);
		request.src = rngState[15:0];
		request.dst = rngState[31:16];
		if (request.op == opAbcd || request.op == opSbcd) begin
			request.src = {rngState[15:8], bcdByte(rngState[7:0])};
			request.dst = {rngState[31:24], bcdByte(rngState[23:16])};
		end
		// Zero operands to reach zero results and the sticky Z case
		if (r[13:11] == 3'b000) begin
			request.src = '0;
			request.dst = '0;
		end
	endtask

	// Advance the model by the edge that follows this falling edge
	task automatic stepModel();
		aluWord res;
		ccrFlags flags;
		ccrFlags nextCcr;
		nextCcr = refCcr;
		if (stageValid) begin
			predict(stageReq, refCcr, res, flags);
			nextCcr = flags;
			expected.push_back(res);
		end
		// Load beats a completing op
		if (ccrLoad) nextCcr = ccrIn;
		refCcr = nextCcr;
		stageValid = valid;
		stageReq = request;
	endtask

	initial begin
		rngState = 32'd14;
		reset = 1'b1;
		valid = 1'b0;
		request = '0;
		ccrLoad = 1'b0;
		ccrIn = '0;
		refCcr = '0;
		stageValid = 1'b0;
		stageReq = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		stepModel();
		// Last cycles idle so the pipeline drains
		for (int i = 0; i < numOps + 3; i++) begin
			@(negedge clk);
			checkOutputs();
			driveRandom(i < numOps);
			stepModel();
		end
		if (errorCount == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			stopOnFailure();
		end
	end

endmodule

`default_nettype wire

// File: test/aluUnit_props.sv
/* Bound timing and flag properties of the ALU top level */
`timescale 1ns/1ns
`default_nettype none

module aluUnitProps (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid,
	input wire logic done,
	input wire logic ccrLoad,
	input wire ccrPkg::ccrFlags ccrIn,
	input wire ccrPkg::ccrFlags ccr,
	input wire logic ctrlValid,
	input wire aluOpsPkg::aluCtrl ctrl
);
	import aluOpsPkg::*;

	logic logicOp;

	// Logic op in its second cycle, about to write the CCR
	assign logicOp = ctrlValid && (ctrl.req.op inside {opAnd, opOr, opEor});

	// Two register stages from request to completion
	doneLatency: assert property (@(posedge clk) disable iff (reset)
		done == $past(valid, 2))
		else $error("done does not follow valid by two cycles");

	doneAfterReset: assert property (@(posedge clk) reset |=> !done)
		else $error("done high right after reset");

	// X is outside the logic flag mask
	logicKeepsX: assert property (@(posedge clk) disable iff (reset)
		logicOp && !ccrLoad |=> $stable(ccr.x))
		else $error("logic operation changed X");

	// Direct load lands at the next edge
	loadTakesCcrIn: assert property (@(posedge clk) disable iff (reset)
		ccrLoad |=> ccr == $past(ccrIn))
		else $error("ccr did not take ccrIn after a load");

endmodule

`default_nettype wire
